/* logic/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and register file sizes
`define DATA_W 32
`define REG_ADDR_W 5

// Cycles after entry into execute until the result can be used
`define TNEW_ALU 1
`define TNEW_MUL 2

`endif

/* logic/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction word, seen as R format or I format
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } iFormat;

    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

    // Operations after decode
    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opSlt,
        opLui,
        opMul,
        opNone
    } aluOp;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        aluOp                   op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`DATA_W-1:0]     rsVal;
        logic [`DATA_W-1:0]     rtVal;
        logic [`DATA_W-1:0]     imm;
        logic                   useImm;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writes;
    } deBundle;

    typedef struct packed {
        aluOp                   op;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writes;
        logic [`DATA_W-1:0]     aluRes;
        // 16 by 16 partial products of a mul
        logic [`DATA_W-1:0]     prodLL;
        logic [`DATA_W-1:0]     prodLH;
        logic [`DATA_W-1:0]     prodHL;
    } erBundle;

    // Register file write port, also the core's result output
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] regNum;
        logic [`DATA_W-1:0]     data;
    } wbPort;

endpackage

/* logic/stageReg.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module stageReg #(
    parameter int PAYLOAD_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic [PAYLOAD_W-1:0] payloadIn,
    input  logic [1:0]           tnewIn,
    output logic [PAYLOAD_W-1:0] payloadOut,
    output logic [1:0]           tnewOut
);

    // An all-zero payload is a bubble with writes low
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            payloadOut <= '0;
            tnewOut    <= 2'd0;
        end
        else
        begin
            payloadOut <= payloadIn;
            // Count down, never below zero
            if (tnewIn != 2'd0)
            begin
                tnewOut <= tnewIn - 2'd1;
            end
            else
            begin
                tnewOut <= 2'd0;
            end
        end
    end

    // No instruction may need more time than a mul
    tnewBound: assert property (
        @(posedge clk) disable iff (rst)
        tnewIn <= 2'(`TNEW_MUL)
    ) else $error("stageReg: tnewIn %0d above mul latency", tnewIn);

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  core_pkg::instrWord     instr,
    input  logic                   instrValid,
    input  core_pkg::wbPort        wb,
    input  logic [`REG_ADDR_W-1:0] eDest,
    input  logic                   eWrites,
    input  logic [1:0]             eTnew,
    output core_pkg::deBundle      dOut,
    output logic [1:0]             dTnew,
    output logic                   stall
);
    import core_pkg::*;

    localparam int NumRegs = 1 << `REG_ADDR_W;

    // Opcode and funct encodings
    localparam logic [5:0] OpSpecial  = 6'h00;
    localparam logic [5:0] OpSpecial2 = 6'h1c;
    localparam logic [5:0] OpAddiu    = 6'h09;
    localparam logic [5:0] OpAndi     = 6'h0c;
    localparam logic [5:0] OpOri      = 6'h0d;
    localparam logic [5:0] OpLui      = 6'h0f;
    localparam logic [5:0] FnAddu     = 6'h21;
    localparam logic [5:0] FnSubu     = 6'h23;
    localparam logic [5:0] FnAnd      = 6'h24;
    localparam logic [5:0] FnOr       = 6'h25;
    localparam logic [5:0] FnSlt      = 6'h2a;
    localparam logic [5:0] FnMul      = 6'h02;

    logic [`DATA_W-1:0]     regs [NumRegs];
    aluOp                   op;
    logic [`REG_ADDR_W-1:0] srcRs;
    logic [`REG_ADDR_W-1:0] srcRt;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`DATA_W-1:0]     imm;
    logic [`DATA_W-1:0]     rsVal;
    logic [`DATA_W-1:0]     rtVal;
    logic                   useImm;
    logic                   writes;
    logic                   hazard;
    logic                   bubble;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid && wb.regNum != '0)
        begin
            regs[wb.regNum] <= wb.data;
        end
    end

    // Write-through so a result retiring this cycle is seen now
    assign rsVal = (srcRs == '0) ? '0 :
                   (wb.valid && wb.regNum == srcRs) ? wb.data : regs[srcRs];
    assign rtVal = (srcRt == '0) ? '0 :
                   (wb.valid && wb.regNum == srcRt) ? wb.data : regs[srcRt];

    ////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        op     = opNone;
        srcRs  = '0;
        srcRt  = '0;
        dest   = '0;
        imm    = '0;
        useImm = 1'b0;
        writes = 1'b0;
        case (instr.r.opcode)
            OpSpecial, OpSpecial2:
            begin
                if (instr.r.opcode == OpSpecial2)
                begin
                    op = (instr.r.funct == FnMul) ? opMul : opNone;
                end
                else
                begin
                    case (instr.r.funct)
                        FnAddu:  op = opAdd;
                        FnSubu:  op = opSub;
                        FnAnd:   op = opAnd;
                        FnOr:    op = opOr;
                        FnSlt:   op = opSlt;
                        default: op = opNone;
                    endcase
                end
                // R view, two sources and rd as target
                if (op != opNone)
                begin
                    srcRs  = instr.r.rs;
                    srcRt  = instr.r.rt;
                    dest   = instr.r.rd;
                    writes = 1'b1;
                end
            end
            OpAddiu, OpAndi, OpOri:
            begin
                op     = (instr.i.opcode == OpAddiu) ? opAdd :
                         (instr.i.opcode == OpAndi)  ? opAnd : opOr;
                srcRs  = instr.i.rs;
                dest   = instr.i.rt;
                useImm = 1'b1;
                writes = 1'b1;
                // Only addiu sign-extends
                if (instr.i.opcode == OpAddiu)
                begin
                    imm = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
                end
                else
                begin
                    imm = {{(`DATA_W-16){1'b0}}, instr.i.imm};
                end
            end
            OpLui:
            begin
                op     = opLui;
                dest   = instr.i.rt;
                imm    = {{(`DATA_W-16){1'b0}}, instr.i.imm};
                useImm = 1'b1;
                writes = 1'b1;
            end
            default:
            begin
                op = opNone;
            end
        endcase
    end

    // A mul still in execute has its product one cycle too late to forward
    assign hazard = eWrites && eTnew != 2'd0 &&
                    ((srcRs != '0 && srcRs == eDest) || (srcRt != '0 && srcRt == eDest));
    assign stall  = instrValid && hazard;
    assign bubble = !instrValid || stall;

    always_comb
    begin
        dOut  = '0;
        dTnew = 2'd0;
        if (!bubble)
        begin
            dOut.op     = op;
            dOut.rs     = srcRs;
            dOut.rt     = srcRt;
            dOut.rsVal  = rsVal;
            dOut.rtVal  = rtVal;
            dOut.imm    = imm;
            dOut.useImm = useImm;
            dOut.dest   = dest;
            dOut.writes = writes;
            if (writes)
            begin
                dTnew = (op == opMul) ? 2'(`TNEW_MUL) : 2'(`TNEW_ALU);
            end
        end
    end

    // The bubble flushed into deReg clears the hazard on the next cycle
    stallOnce: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> !stall
    ) else $error("decodeStage: stall high on two consecutive cycles");

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module executeStage (
    input  core_pkg::deBundle      dIn,
    input  logic [`REG_ADDR_W-1:0] fwdReg,
    input  logic [`DATA_W-1:0]     fwdData,
    input  logic                   fwdReady,
    output core_pkg::erBundle      eOut
);
    import core_pkg::*;

    localparam int HalfW = `DATA_W / 2;

    logic [`DATA_W-1:0] rsVal;
    logic [`DATA_W-1:0] rtVal;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] aluRes;
    logic               lessThan;

    ////////////////////////////////////////////////////////////
    // Operand forwarding from the result stage
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        rsVal = dIn.rsVal;
        rtVal = dIn.rtVal;
        // fwdReg is zero when nothing is being written
        if (fwdReady && dIn.rs != '0 && dIn.rs == fwdReg)
        begin
            rsVal = fwdData;
        end
        if (fwdReady && dIn.rt != '0 && dIn.rt == fwdReg)
        begin
            rtVal = fwdData;
        end
    end

    assign opB      = dIn.useImm ? dIn.imm : rtVal;
    assign lessThan = $signed(rsVal) < $signed(opB);

    // ALU
    always_comb
    begin
        case (dIn.op)
            opAdd:   aluRes = rsVal + opB;
            opSub:   aluRes = rsVal - opB;
            opAnd:   aluRes = rsVal & opB;
            opOr:    aluRes = rsVal | opB;
            opSlt:   aluRes = {{(`DATA_W-1){1'b0}}, lessThan};
            opLui:   aluRes = {dIn.imm[HalfW-1:0], {HalfW{1'b0}}};
            default: aluRes = '0;
        endcase
    end

    // First half of the multiply, high by high drops out of the low word
    always_comb
    begin
        eOut        = '0;
        eOut.op     = dIn.op;
        eOut.dest   = dIn.dest;
        eOut.writes = dIn.writes;
        eOut.aluRes = aluRes;
        if (dIn.op == opMul)
        begin
            eOut.prodLL = rsVal[HalfW-1:0] * rtVal[HalfW-1:0];
            eOut.prodLH = rsVal[HalfW-1:0] * rtVal[`DATA_W-1:HalfW];
            eOut.prodHL = rsVal[`DATA_W-1:HalfW] * rtVal[HalfW-1:0];
        end
    end

endmodule

/* logic/resultStage.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module resultStage (
    input  core_pkg::erBundle      rIn,
    input  logic [1:0]             rTnew,
    output core_pkg::wbPort        wb,
    output logic [`REG_ADDR_W-1:0] fwdReg,
    output logic [`DATA_W-1:0]     fwdData,
    output logic                   fwdReady
);
    import core_pkg::*;

    localparam int HalfW = `DATA_W / 2;

    logic [`DATA_W-1:0] mulLow;
    logic [`DATA_W-1:0] value;
    logic               writeBack;

    ////////////////////////////////////////////////////////////
    // Multiply completion
    ////////////////////////////////////////////////////////////

    // Cross products only land in the upper half of the low word
    assign mulLow = rIn.prodLL
                  + {rIn.prodLH[HalfW-1:0], {HalfW{1'b0}}}
                  + {rIn.prodHL[HalfW-1:0], {HalfW{1'b0}}};

    assign value     = (rIn.op == opMul) ? mulLow : rIn.aluRes;
    assign writeBack = rIn.writes && rIn.dest != '0;

    // Write-back port
    assign wb.valid  = writeBack;
    assign wb.regNum = rIn.dest;
    assign wb.data   = value;

    // Forward path back into execute
    assign fwdReg   = writeBack ? rIn.dest : '0;
    assign fwdData  = value;
    assign fwdReady = (rTnew == 2'd0);

    // Decode must never mark an unsupported word as writing
    always_comb
    begin
        assert (!wb.valid || rIn.op != opNone)
        else $error("resultStage: write-back to r%0d with op %s",
                    wb.regNum, rIn.op.name());
    end

endmodule

/* logic/pipeCore.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module pipeCore (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::instrWord instr,
    input  logic               instrValid,
    output logic               stall,
    output core_pkg::wbPort    wb
);
    import core_pkg::*;

    deBundle                dBundle;
    deBundle                eBundle;
    erBundle                xBundle;
    erBundle                rBundle;
    logic [1:0]             dTnew;
    logic [1:0]             eTnew;
    logic [1:0]             rTnew;
    logic [`REG_ADDR_W-1:0] fwdReg;
    logic [`DATA_W-1:0]     fwdData;
    logic                   fwdReady;

    decodeStage uDecode (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .wb         (wb),
        .eDest      (eBundle.dest),
        .eWrites    (eBundle.writes),
        .eTnew      (eTnew),
        .dOut       (dBundle),
        .dTnew      (dTnew),
        .stall      (stall)
    );

    // Stalls flush this register instead of holding it
    stageReg #(.PAYLOAD_W($bits(deBundle))) deReg (
        .clk        (clk),
        .rst        (rst),
        .flush      (stall),
        .payloadIn  (dBundle),
        .tnewIn     (dTnew),
        .payloadOut (eBundle),
        .tnewOut    (eTnew)
    );

    executeStage uExecute (
        .dIn      (eBundle),
        .fwdReg   (fwdReg),
        .fwdData  (fwdData),
        .fwdReady (fwdReady),
        .eOut     (xBundle)
    );

    stageReg #(.PAYLOAD_W($bits(erBundle))) erReg (
        .clk        (clk),
        .rst        (rst),
        .flush      (1'b0),
        .payloadIn  (xBundle),
        .tnewIn     (eTnew),
        .payloadOut (rBundle),
        .tnewOut    (rTnew)
    );

    resultStage uResult (
        .rIn      (rBundle),
        .rTnew    (rTnew),
        .wb       (wb),
        .fwdReg   (fwdReg),
        .fwdData  (fwdData),
        .fwdReady (fwdReady)
    );

endmodule

/* test/coreModel.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// MIPS encodings of the supported subset
localparam logic [5:0] OpcSpecial  = 6'h00;
localparam logic [5:0] OpcSpecial2 = 6'h1c;
localparam logic [5:0] OpcAddiu    = 6'h09;
localparam logic [5:0] OpcAndi     = 6'h0c;
localparam logic [5:0] OpcOri      = 6'h0d;
localparam logic [5:0] OpcLui      = 6'h0f;
localparam logic [5:0] FnAddu      = 6'h21;
localparam logic [5:0] FnSubu      = 6'h23;
localparam logic [5:0] FnAnd       = 6'h24;
localparam logic [5:0] FnOr        = 6'h25;
localparam logic [5:0] FnSlt       = 6'h2a;
localparam logic [5:0] FnMul       = 6'h02;

////////////////////////////////////////////////////////////
// Architectural model of one instruction
////////////////////////////////////////////////////////////

function automatic core_pkg::wbPort refResult(input logic [31:0] w);
    core_pkg::wbPort    res;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] sImm;
    logic [`DATA_W-1:0] zImm;
    res        = '0;
    a          = modelRegs[w[25:21]];
    b          = modelRegs[w[20:16]];
    sImm       = {{16{w[15]}}, w[15:0]};
    zImm       = {16'd0, w[15:0]};
    res.valid  = 1'b1;
    res.regNum = w[20:16];
    case (w[31:26])
        OpcSpecial:
        begin
            res.regNum = w[15:11];
            case (w[5:0])
                FnAddu:  res.data = a + b;
                FnSubu:  res.data = a - b;
                FnAnd:   res.data = a & b;
                FnOr:    res.data = a | b;
                FnSlt:   res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: res.valid = 1'b0;
            endcase
        end
        OpcSpecial2:
        begin
            res.regNum = w[15:11];
            res.data   = a * b;
            res.valid  = (w[5:0] == FnMul);
        end
        OpcAddiu: res.data = a + sImm;
        OpcAndi:  res.data = a & zImm;
        OpcOri:   res.data = a | zImm;
        OpcLui:   res.data = {w[15:0], 16'd0};
        default:  res.valid = 1'b0;
    endcase
    // r0 is hardwired to zero
    if (res.regNum == '0)
    begin
        res.valid = 1'b0;
    end
    return res;
endfunction

////////////////////////////////////////////////////////////
// Program generator
////////////////////////////////////////////////////////////

function automatic logic [31:0] rTypeWord(input logic [5:0] opcode, input logic [5:0] funct,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd);
    return {opcode, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] immWord(input logic [5:0] opcode, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {opcode, rs, rt, imm};
endfunction

function automatic logic [31:0] randomAluWord(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd);
    logic [15:0] imm;
    imm = 16'($urandom);
    case ($urandom_range(7, 0))
        0:       return rTypeWord(OpcSpecial, FnAddu, rs, rt, rd);
        1:       return rTypeWord(OpcSpecial, FnSubu, rs, rt, rd);
        2:       return rTypeWord(OpcSpecial, FnAnd, rs, rt, rd);
        3:       return rTypeWord(OpcSpecial, FnOr, rs, rt, rd);
        4:       return rTypeWord(OpcSpecial, FnSlt, rs, rt, rd);
        5:       return immWord(OpcAddiu, rs, rd, imm);
        6:       return immWord(OpcAndi, rs, rd, imm);
        default: return immWord(OpcOri, rs, rd, imm);
    endcase
endfunction

// One program word and the stall cycles it should see
task automatic addWord(input logic [31:0] w, input int wantStall);
    progWords.push_back(w);
    stallWant.push_back(wantStall);
endtask

task automatic buildPrograms();
    logic [4:0] prev;
    logic [4:0] twoBack;
    logic [4:0] dest;
    testName     = '{"idle after reset", "random ALU", "dependent chain", "mul hazard",
                     "r0 and unsupported"};
    testStart[0] = 0;
    testStart[1] = 0;
    // Load r1..r8, then independent ops into r16..r31
    for (int r = 1; r <= 8; r++)
    begin
        addWord(immWord(OpcLui, 5'd0, 5'(r), 16'($urandom)), 0);
        addWord(immWord(OpcOri, 5'(r), 5'(r), 16'($urandom)), 0);
    end
    for (int i = 0; i < 24; i++)
    begin
        addWord(randomAluWord(5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)),
                              5'($urandom_range(31, 16))), 0);
    end
    // rs is one behind (forward), rt two behind (write-through)
    testStart[2] = progWords.size();
    prev         = 5'd1;
    twoBack      = 5'd2;
    for (int i = 0; i < 16; i++)
    begin
        dest = 5'(9 + i % 7);
        addWord(randomAluWord(prev, twoBack, dest), 0);
        twoBack = prev;
        prev    = dest;
    end
    testStart[3] = progWords.size();
    for (int k = 0; k < 4; k++)
    begin
        dest = 5'(20 + k);
        addWord(rTypeWord(OpcSpecial2, FnMul, 5'($urandom_range(15, 1)),
                          5'($urandom_range(15, 1)), dest), 0);
        // Consumer right behind a mul waits one cycle
        if (k % 2 == 0)
        begin
            addWord(rTypeWord(OpcSpecial, FnAddu, dest, 5'd1, 5'd25), 1);
        end
        else
        begin
            addWord(rTypeWord(OpcSpecial, FnSubu, 5'd2, dest, 5'd25), 1);
        end
        addWord(rTypeWord(OpcSpecial2, FnMul, dest, 5'($urandom_range(8, 1)), 5'd24), 0);
        addWord(immWord(OpcOri, 5'd3, 5'd26, 16'($urandom)), 0);
        addWord(immWord(OpcAddiu, 5'd24, 5'd27, 16'($urandom)), 0);
    end
    testStart[4] = progWords.size();
    addWord(rTypeWord(OpcSpecial, FnAddu, 5'd1, 5'd2, 5'd0), 0);
    addWord(immWord(OpcOri, 5'd3, 5'd0, 16'hbeef), 0);
    addWord(immWord(OpcLui, 5'd0, 5'd0, 16'h1234), 0);
    addWord(rTypeWord(OpcSpecial2, FnMul, 5'd4, 5'd5, 5'd0), 0);
    addWord(rTypeWord(OpcSpecial, FnAddu, 5'd0, 5'd6, 5'd28), 0);
    // sll, madd, lw and an all-ones word
    addWord(rTypeWord(OpcSpecial, 6'h00, 5'd1, 5'd2, 5'd29), 0);
    addWord(rTypeWord(OpcSpecial2, 6'h00, 5'd1, 5'd2, 5'd29), 0);
    addWord(32'h8c22_0004, 0);
    addWord(32'hffff_ffff, 0);
    addWord(rTypeWord(OpcSpecial, FnOr, 5'd0, 5'd0, 5'd30), 0);
    addWord(immWord(OpcAddiu, 5'd0, 5'd31, 16'hfff0), 0);
    testStart[5] = progWords.size();
endtask

`endif

/* test/coreTb.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module coreTb;
    import core_pkg::*;

    localparam int ClkPeriod = 40;
    localparam int NumTests  = 5;
    localparam int NumRegs   = 1 << `REG_ADDR_W;

    logic               clk;
    logic               rst;
    instrWord           instr;
    logic               instrValid;
    logic               stall;
    wbPort              wbOut;

    logic [`DATA_W-1:0] modelRegs [NumRegs];
    logic [31:0]        progWords [$];
    int                 stallWant [$];
    wbPort              expected [$];
    int                 testStart [NumTests + 1];
    string              testName [NumTests];
    logic               programBuilt;
    int                 errorCount;
    int                 testsPassed;
    int                 testsFailed;

    `include "coreModel.svh"

    pipeCore u_dut (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .wb         (wbOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want)
        begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Holds the word through any stall, then models it at acceptance
    task automatic issueWord(input int idx);
        int    waited;
        wbPort res;
        waited = 0;
        @(posedge clk);
        instr      <= progWords[idx];
        instrValid <= 1'b1;
        @(negedge clk);
        while (stall)
        begin
            waited++;
            @(negedge clk);
        end
        checkValue($sformatf("stall cycles of word %0d", idx), waited, stallWant[idx]);
        res = refResult(progWords[idx]);
        if (res.valid)
        begin
            expected.push_back(res);
            modelRegs[res.regNum] = res.data;
        end
    endtask

    task automatic runTest(input int t);
        int errsBefore;
        errsBefore = errorCount;
        for (int i = testStart[t]; i < testStart[t + 1]; i++)
        begin
            issueWord(i);
        end
        @(posedge clk);
        instrValid <= 1'b0;
        while (expected.size() != 0)
        begin
            @(negedge clk);
        end
        // Idle pipe, any write-back now is a stray one
        repeat (3)
        begin
            @(negedge clk);
            checkValue("stall while idle", 32'(stall), 32'd0);
        end
        if (errorCount == errsBefore)
        begin
            testsPassed++;
            $display("test %0d (%s): ok", t, testName[t]);
        end
        else
        begin
            testsFailed++;
            $display("test %0d (%s): %0d errors", t, testName[t], errorCount - errsBefore);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare against the model, in program order
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin : compareWb
        wbPort want;
        if (!rst && wbOut.valid)
        begin
            if (expected.size() == 0)
            begin
                $display("Write-back to r%0d at %0t ns with no instruction expected to write",
                         wbOut.regNum, $time);
                errorCount++;
            end
            else
            begin
                want = expected.pop_front();
                checkValue("write-back register", 32'(wbOut.regNum), 32'(want.regNum));
                checkValue($sformatf("data of r%0d", want.regNum), wbOut.data, want.data);
            end
        end
    end

    // Each word takes at most three cycles, plus margin for reset and idle gaps
    initial
    begin : watchdog
        int limitCycles;
        wait (programBuilt);
        limitCycles = progWords.size() * 3 + 50;
        #(limitCycles * ClkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h1aa8a574));
        rst          = 1'b1;
        instr        = '0;
        instrValid   = 1'b0;
        programBuilt = 1'b0;
        errorCount   = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        for (int r = 0; r < NumRegs; r++)
        begin
            modelRegs[r] = '0;
        end
        buildPrograms();
        programBuilt = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < NumTests; t++)
        begin
            runTest(t);
        end
        $display("%0d of %0d tests passed, %0d failed, %0d errors",
                 testsPassed, NumTests, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
+incdir+test
logic/core_pkg.sv
logic/stageReg.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/pipeCore.sv
test/coreTb.sv

/* run.sh */
#!/bin/sh
# Build coreTb with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module coreTb -f src.f -o coreSim \
    > build.log 2>&1 \
    && ./obj_dir/coreSim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
grep -qx "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
